// File: src.f
+incdir+bench
hdl/ik_pkg.sv
hdl/ik_joint_update.sv
hdl/ik_sequencer.sv
hdl/ik_regs.sv
hdl/ik_top.sv
bench/ik_tb.sv

// File: bench/ik_model.svh
// bus access tasks and the reference model of the solver step rule
// included inside the testbench module body, drives its bus signals
`ifndef IK_MODEL_SVH
`define IK_MODEL_SVH

// the DUT samples the access on the second edge
task automatic bus_write(input logic [5:0] addr, input logic [31:0] data);
	@(posedge clk);
	chipselect <= 1'b1;
	write      <= 1'b1;
	address    <= addr;
	writedata  <= data;
	@(posedge clk);
	chipselect <= 1'b0;
	write      <= 1'b0;
endtask

// same cycle shape but chipselect stays low
task automatic ignored_write(input logic [5:0] addr, input logic [31:0] data);
	@(posedge clk);
	chipselect <= 1'b0;
	write      <= 1'b1;
	address    <= addr;
	writedata  <= data;
	@(posedge clk);
	write      <= 1'b0;
endtask

// readdata is registered, taken at the following falling edge
task automatic bus_read(input logic [5:0] addr, output logic [31:0] data);
	@(posedge clk);
	chipselect <= 1'b1;
	write      <= 1'b0;
	address    <= addr;
	@(posedge clk);
	chipselect <= 1'b0;
	@(negedge clk);
	data = readdata;
endtask

function automatic longint sign_extend(input logic [31:0] value, input int width);
	longint wide;
	wide = longint'(value);
	wide = wide <<< (64 - width);
	return wide >>> (64 - width);
endfunction

// one relaxation step, an eighth of the error, clipped to the angle range
function automatic longint step_angle(input longint angle_val, input longint target_val);
	longint sum;
	longint hi;
	longint lo;
	hi  = (longint'(1) <<< (ANGLE_W - 1)) - 1;
	lo  = -(longint'(1) <<< (ANGLE_W - 1));
	sum = angle_val + ((target_val - angle_val) >>> STEP_SHIFT);
	if (sum > hi) sum = hi;
	else if (sum < lo) sum = lo;
	return sum;
endfunction

// runs every pass over all joints from the words last loaded
task automatic solve_model();
	int     passes;
	longint tgt [3];
	passes = (iter_word[ITER_W-1:0] == 0) ? 1 : int'(iter_word[ITER_W-1:0]);
	for (int k = 0; k < 3; k++) tgt[k] = sign_extend(tgt_word[k], TARGET_W);
	for (int i = 0; i < NUM_JOINT; i++) model_ang[i] = sign_extend(ang_word[i], ANGLE_W);
	for (int p = 0; p < passes; p++) begin
		// joint i follows axis i mod 3
		for (int i = 0; i < NUM_JOINT; i++) model_ang[i] = step_angle(model_ang[i], tgt[i % 3]);
	end
endtask

`endif

// File: bench/ik_tb.sv
// drives the IK solver block through its bus with register checks, random solves,
// saturation corners and a restart sequence
module ik_tb;

	import ik_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_RUNS   = 40;
	localparam int TOTAL_RUNS = NUM_RUNS + 6;
	localparam int MAX_PASSES = 15;
	// loose bound on cycles per pass including the surrounding bus traffic
	localparam int PASS_BOUND = 200;
	localparam int POLL_LIMIT = 500;

	logic        clk;
	logic        reset;
	logic        chipselect;
	logic        write;
	logic [5:0]  address;
	logic [31:0] writedata;
	logic [31:0] readdata;

	int          error_count;
	logic [31:0] rdata;
	logic [31:0] tgt_word [3];
	logic [31:0] ang_word [NUM_JOINT];
	logic [31:0] iter_word;
	longint      model_ang [NUM_JOINT];

	`include "ik_model.svh"

	ik_top i_dut (
		.clk        (clk),
		.reset      (reset),
		.chipselect (chipselect),
		.write      (write),
		.address    (address),
		.writedata  (writedata),
		.readdata   (readdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TOTAL_RUNS * MAX_PASSES * PASS_BOUND * CLK_PERIOD);
		$display("timeout: the tests did not finish in the allowed time");
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	function automatic logic [5:0] angle_addr(input int i);
		return 6'(ADDR_ANGLE_BASE + ADDR_ANGLE_STRIDE * i);
	endfunction

	function automatic logic [5:0] target_addr(input int k);
		return (k == 0) ? ADDR_TGT_X : (k == 1) ? ADDR_TGT_Y : ADDR_TGT_Z;
	endfunction

	task automatic load_operands();
		for (int k = 0; k < 3; k++) bus_write(target_addr(k), tgt_word[k]);
		for (int i = 0; i < NUM_JOINT; i++) bus_write(angle_addr(i), ang_word[i]);
		bus_write(ADDR_ITER, iter_word);
	endtask

	// narrow targets keep most runs out of saturation
	task automatic randomize_operands(input bit narrow);
		for (int k = 0; k < 3; k++) begin
			tgt_word[k] = narrow ? 32'(sign_extend($urandom, 22)) : $urandom;
		end
		for (int i = 0; i < NUM_JOINT; i++) ang_word[i] = $urandom;
		iter_word = $urandom % 16;
	endtask

	task automatic wait_done(input string name);
		int          polls;
		logic [31:0] status;
		polls  = 0;
		status = '0;
		while (!status[0] && polls < POLL_LIMIT) begin
			bus_read(ADDR_CTRL, status);
			polls++;
		end
		if (!status[0]) begin
			$display("error: %s never raised done", name);
			error_count++;
		end
	endtask

	task automatic check_angles(input string name);
		for (int i = 0; i < NUM_JOINT; i++) begin
			bus_read(angle_addr(i), rdata);
			compare($sformatf("%s angle %0d", name, i), 32'(model_ang[i]), rdata);
		end
	endtask

	// done must drop once enable is written low
	task automatic clear_enable(input string name);
		bus_write(ADDR_CTRL, 32'd0);
		bus_read(ADDR_CTRL, rdata);
		compare({name, " done clear"}, 32'd0, rdata);
	endtask

	task automatic run_and_check(input string name);
		load_operands();
		solve_model();
		bus_write(ADDR_CTRL, 32'd1);
		wait_done(name);
		check_angles(name);
		clear_enable(name);
	endtask

	task automatic check_reset_values();
		bus_read(ADDR_TYPE, rdata);
		compare("reset type", 32'h0000_003f, rdata);
		bus_read(ADDR_CTRL, rdata);
		compare("reset ctrl", 32'd0, rdata);
		bus_read(ADDR_ITER, rdata);
		compare("reset iter", 32'd1, rdata);
		for (int k = 0; k < 3; k++) begin
			bus_read(target_addr(k), rdata);
			compare($sformatf("reset target %0d", k), 32'd0, rdata);
		end
		for (int i = 0; i < NUM_JOINT; i++) begin
			bus_read(angle_addr(i), rdata);
			compare($sformatf("reset angle %0d", i), 32'd0, rdata);
		end
	endtask

	task automatic check_register_readback();
		for (int n = 0; n < 8; n++) begin
			for (int k = 0; k < 3; k++) begin
				tgt_word[k] = $urandom;
				bus_write(target_addr(k), tgt_word[k]);
				bus_read(target_addr(k), rdata);
				compare($sformatf("readback target %0d", k),
					32'(sign_extend(tgt_word[k], TARGET_W)), rdata);
			end
			iter_word = $urandom;
			bus_write(ADDR_ITER, iter_word);
			bus_read(ADDR_ITER, rdata);
			compare("readback iter", {28'd0, iter_word[3:0]}, rdata);
		end
		// accesses without chipselect must leave the registers alone
		ignored_write(ADDR_TGT_X, ~tgt_word[0]);
		ignored_write(ADDR_ITER, ~iter_word);
		bus_read(ADDR_TGT_X, rdata);
		compare("no cs target", 32'(sign_extend(tgt_word[0], TARGET_W)), rdata);
		bus_read(ADDR_ITER, rdata);
		compare("no cs iter", {28'd0, iter_word[3:0]}, rdata);
	endtask

	// opposite extremes for target and angle on every joint
	task automatic check_saturation();
		for (int c = 0; c < 4; c++) begin
			for (int k = 0; k < 3; k++) begin
				tgt_word[k] = ((c + k) % 2 == 0) ? 32'h03ff_ffff : 32'h0400_0000;
			end
			for (int i = 0; i < NUM_JOINT; i++) begin
				ang_word[i] = ((c + i) % 2 == 0) ? 32'h0010_0000 : 32'h000f_ffff;
			end
			iter_word = 32'(c * 5);
			run_and_check($sformatf("saturation %0d", c));
		end
	endtask

	task automatic check_restart();
		randomize_operands(1'b0);
		iter_word = 32'd15;
		load_operands();
		solve_model();
		bus_write(ADDR_CTRL, 32'd1);
		// new operands land while the first run is still busy
		randomize_operands(1'b1);
		load_operands();
		wait_done("restart busy");
		check_angles("restart busy");
		clear_enable("restart busy");
		solve_model();
		bus_write(ADDR_CTRL, 32'd1);
		wait_done("restart second");
		check_angles("restart second");
		clear_enable("restart second");
	endtask

	initial begin
		logic [31:0] seed_val;
		reset       = 1'b1;
		chipselect  = 1'b0;
		write       = 1'b0;
		address     = '0;
		writedata   = '0;
		error_count = 0;
		seed_val    = 32'h5643;
		seed_val    = $urandom(seed_val);
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		check_reset_values();
		check_register_readback();
		for (int r = 0; r < NUM_RUNS; r++) begin
			randomize_operands(r[0]);
			run_and_check($sformatf("solve run %0d", r));
		end
		check_saturation();
		check_restart();

		$display("errors: %0d", error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: hdl/ik_top.sv
// top level of the memory-mapped IK solver
// connects the register file, the run sequencer and the step unit
module ik_top (
	input  logic        clk,
	input  logic        reset,

	input  logic        chipselect,
	input  logic        write,
	input  logic [5:0]  address,
	input  logic [31:0] writedata,
	output logic [31:0] readdata
);

	import ik_pkg::*;

	// register file to sequencer
	logic                       enable;
	logic signed [TARGET_W-1:0] target_x;
	logic signed [TARGET_W-1:0] target_y;
	logic signed [TARGET_W-1:0] target_z;
	logic signed [ANGLE_W-1:0]  start_angle [NUM_JOINT];
	logic [ITER_W-1:0]          iter_count;

	// sequencer to register file
	logic                       done;
	logic signed [ANGLE_W-1:0]  angle [NUM_JOINT];

	// issue path
	logic                       issue_valid;
	logic [JOINT_IDX_W-1:0]     issue_joint;
	logic signed [ANGLE_W-1:0]  issue_angle;
	logic signed [TARGET_W-1:0] issue_target;

	// write-back path
	logic                       result_valid;
	logic [JOINT_IDX_W-1:0]     result_joint;
	logic signed [ANGLE_W-1:0]  result_angle;

	ik_regs i_regs (
		.clk         (clk),
		.reset       (reset),
		.chipselect  (chipselect),
		.write       (write),
		.address     (address),
		.writedata   (writedata),
		.readdata    (readdata),
		.enable      (enable),
		.target_x    (target_x),
		.target_y    (target_y),
		.target_z    (target_z),
		.start_angle (start_angle),
		.iter_count  (iter_count),
		.done        (done),
		.angle       (angle)
	);

	ik_sequencer i_sequencer (
		.clk          (clk),
		.reset        (reset),
		.enable       (enable),
		.target_x     (target_x),
		.target_y     (target_y),
		.target_z     (target_z),
		.start_angle  (start_angle),
		.iter_count   (iter_count),
		.done         (done),
		.angle        (angle),
		.issue_valid  (issue_valid),
		.issue_joint  (issue_joint),
		.issue_angle  (issue_angle),
		.issue_target (issue_target),
		.result_valid (result_valid),
		.result_joint (result_joint),
		.result_angle (result_angle)
	);

	ik_joint_update i_joint_update (
		.clk          (clk),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.issue_joint  (issue_joint),
		.issue_angle  (issue_angle),
		.issue_target (issue_target),
		.result_valid (result_valid),
		.result_joint (result_joint),
		.result_angle (result_angle)
	);

endmodule

// File: hdl/ik_regs.sv
// bus-facing register file of the IK solver
// decodes chipselect/write accesses and returns a registered, sign-extended readback
module ik_regs (
	input  logic clk,
	input  logic reset,

	// bus side
	input  logic        chipselect,
	input  logic        write,
	input  logic [5:0]  address,
	input  logic [31:0] writedata,
	output logic [31:0] readdata,

	// operands toward the sequencer
	output logic                                enable,
	output logic signed [ik_pkg::TARGET_W-1:0]  target_x,
	output logic signed [ik_pkg::TARGET_W-1:0]  target_y,
	output logic signed [ik_pkg::TARGET_W-1:0]  target_z,
	output logic signed [ik_pkg::ANGLE_W-1:0]   start_angle [ik_pkg::NUM_JOINT],
	output logic        [ik_pkg::ITER_W-1:0]    iter_count,

	// status and results from the sequencer
	input  logic                                done,
	input  logic signed [ik_pkg::ANGLE_W-1:0]   angle [ik_pkg::NUM_JOINT]
);

	import ik_pkg::*;

	logic wr_en;
	logic rd_en;

	assign wr_en = chipselect && write;
	assign rd_en = chipselect && !write;

	// write decode
	always_ff @(posedge clk) begin
		if (reset) begin
			enable     <= 1'b0;
			target_x   <= '0;
			target_y   <= '0;
			target_z   <= '0;
			iter_count <= ITER_W'(1);
			for (int i = 0; i < NUM_JOINT; i++) begin
				start_angle[i] <= '0;
			end
		end else if (wr_en) begin
			case (address)
				// level-type start bit
				ADDR_CTRL:  enable     <= writedata[0];
				ADDR_ITER:  iter_count <= writedata[ITER_W-1:0];
				ADDR_TGT_X: target_x   <= writedata[TARGET_W-1:0];
				ADDR_TGT_Y: target_y   <= writedata[TARGET_W-1:0];
				ADDR_TGT_Z: target_z   <= writedata[TARGET_W-1:0];
				default: ;
			endcase
			// start angles at the strided addresses
			for (int i = 0; i < NUM_JOINT; i++) begin
				if (address == 6'(ADDR_ANGLE_BASE + ADDR_ANGLE_STRIDE * i)) begin
					start_angle[i] <= writedata[ANGLE_W-1:0];
				end
			end
		end
	end

	// registered read mux, unmapped reads hold the last value
	always_ff @(posedge clk) begin
		if (reset) begin
			readdata <= '0;
		end else if (rd_en) begin
			case (address)
				ADDR_TYPE: readdata <= 32'(JOINT_TYPE);
				// done shows up in bit 0
				ADDR_CTRL: readdata <= 32'(done);
				ADDR_ITER: readdata <= 32'(iter_count);
				ADDR_TGT_X: begin
					readdata <= {{(32-TARGET_W){target_x[TARGET_W-1]}}, target_x};
				end
				ADDR_TGT_Y: begin
					readdata <= {{(32-TARGET_W){target_y[TARGET_W-1]}}, target_y};
				end
				ADDR_TGT_Z: begin
					readdata <= {{(32-TARGET_W){target_z[TARGET_W-1]}}, target_z};
				end
				default: ;
			endcase
			// angle reads return the working angles, not the start values
			for (int i = 0; i < NUM_JOINT; i++) begin
				if (address == 6'(ADDR_ANGLE_BASE + ADDR_ANGLE_STRIDE * i)) begin
					readdata <= {{(32-ANGLE_W){angle[i][ANGLE_W-1]}}, angle[i]};
				end
			end
		end
	end

endmodule

// File: hdl/ik_sequencer.sv
// run control of the IK solver: captures operands on the start edge,
// issues joints pass by pass to the step unit and holds the working angles
module ik_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic enable,

	input  logic signed [ik_pkg::TARGET_W-1:0]    target_x,
	input  logic signed [ik_pkg::TARGET_W-1:0]    target_y,
	input  logic signed [ik_pkg::TARGET_W-1:0]    target_z,
	input  logic signed [ik_pkg::ANGLE_W-1:0]     start_angle [ik_pkg::NUM_JOINT],
	input  logic        [ik_pkg::ITER_W-1:0]      iter_count,

	output logic                                  done,
	output logic signed [ik_pkg::ANGLE_W-1:0]     angle [ik_pkg::NUM_JOINT],

	// toward the step unit
	output logic                                  issue_valid,
	output logic        [ik_pkg::JOINT_IDX_W-1:0] issue_joint,
	output logic signed [ik_pkg::ANGLE_W-1:0]     issue_angle,
	output logic signed [ik_pkg::TARGET_W-1:0]    issue_target,

	// back from the step unit
	input  logic                                  result_valid,
	input  logic        [ik_pkg::JOINT_IDX_W-1:0] result_joint,
	input  logic signed [ik_pkg::ANGLE_W-1:0]     result_angle
);

	import ik_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_RUN, S_DRAIN, S_DONE} state_t;

	state_t                     state;
	logic                       enable_q;
	logic                       start;
	logic                       last_joint;
	logic [JOINT_IDX_W-1:0]     joint_cnt;
	logic [ITER_W-1:0]          pass_cnt;
	logic signed [TARGET_W-1:0] tgt_x;
	logic signed [TARGET_W-1:0] tgt_y;
	logic signed [TARGET_W-1:0] tgt_z;

	// rising edge of the level enable, only honoured when idle
	assign start      = (state == S_IDLE) && enable && !enable_q;
	assign last_joint = (joint_cnt == JOINT_IDX_W'(NUM_JOINT - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= S_IDLE;
			enable_q  <= 1'b0;
			joint_cnt <= '0;
			pass_cnt  <= '0;
		end else begin
			enable_q <= enable;
			case (state)
				S_IDLE: if (start) begin
					joint_cnt <= '0;
					// a zero count still runs one pass
					pass_cnt  <= (iter_count == '0) ? ITER_W'(1) : iter_count;
					state     <= S_RUN;
				end
				S_RUN: begin
					if (last_joint) begin
						joint_cnt <= '0;
						pass_cnt  <= pass_cnt - 1'b1;
						if (pass_cnt == ITER_W'(1)) state <= S_DRAIN;
					end else begin
						joint_cnt <= joint_cnt + 1'b1;
					end
				end
				// wait for the final joint to be written back
				S_DRAIN: if (result_valid && result_joint == JOINT_IDX_W'(NUM_JOINT - 1)) begin
					state <= S_DONE;
				end
				S_DONE: if (!enable) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// operand snapshot, later register writes do not disturb the run
	always_ff @(posedge clk) begin
		if (start) begin
			tgt_x <= target_x;
			tgt_y <= target_y;
			tgt_z <= target_z;
		end
	end

	// working angles
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_JOINT; i++) angle[i] <= '0;
		end else if (start) begin
			angle <= start_angle;
		end else if (result_valid) begin
			angle[result_joint] <= result_angle;
		end
	end

	assign done        = (state == S_DONE);
	assign issue_valid = (state == S_RUN);
	assign issue_joint = joint_cnt;

	// forward a result landing on the same cycle
	assign issue_angle = (result_valid && result_joint == joint_cnt) ? result_angle
		: angle[joint_cnt];

	always_comb begin
		case (axis_of(joint_cnt))
			2'd0:    issue_target = tgt_x;
			2'd1:    issue_target = tgt_y;
			default: issue_target = tgt_z;
		endcase
	end

endmodule

// File: hdl/ik_joint_update.sv
// two-stage step unit: moves one joint angle an eighth of the way to its target
// accepts one operand set per cycle, result two cycles later, never stalls
module ik_joint_update (
	input  logic clk,
	input  logic reset,

	input  logic                                  issue_valid,
	input  logic        [ik_pkg::JOINT_IDX_W-1:0] issue_joint,
	input  logic signed [ik_pkg::ANGLE_W-1:0]     issue_angle,
	input  logic signed [ik_pkg::TARGET_W-1:0]    issue_target,

	output logic                                  result_valid,
	output logic        [ik_pkg::JOINT_IDX_W-1:0] result_joint,
	output logic signed [ik_pkg::ANGLE_W-1:0]     result_angle
);

	import ik_pkg::*;

	// stage 1 state
	logic                       s1_valid;
	logic [JOINT_IDX_W-1:0]     s1_joint;
	logic signed [ANGLE_W-1:0]  s1_angle;
	logic signed [TARGET_W:0]   s1_err;

	// stage 2 combinational
	logic signed [TARGET_W:0]   step;
	logic signed [TARGET_W:0]   sum;
	logic signed [ANGLE_W-1:0]  sat;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid     <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			s1_valid     <= issue_valid;
			result_valid <= s1_valid;
		end
	end

	// one bit wider than the target so the difference cannot wrap
	always_ff @(posedge clk) begin
		s1_joint <= issue_joint;
		s1_angle <= issue_angle;
		s1_err   <= {issue_target[TARGET_W-1], issue_target}
			- {{(TARGET_W+1-ANGLE_W){issue_angle[ANGLE_W-1]}}, issue_angle};
	end

	always_comb begin
		// arithmetic shift floors toward minus infinity
		step = s1_err >>> STEP_SHIFT;
		sum  = step + {{(TARGET_W+1-ANGLE_W){s1_angle[ANGLE_W-1]}}, s1_angle};
		// in range when every bit above the angle's sign bit agrees with it
		if (&sum[TARGET_W:ANGLE_W-1] || ~|sum[TARGET_W:ANGLE_W-1]) begin
			sat = sum[ANGLE_W-1:0];
		end else if (sum[TARGET_W]) begin
			sat = {1'b1, {(ANGLE_W-1){1'b0}}};
		end else begin
			sat = {1'b0, {(ANGLE_W-1){1'b1}}};
		end
	end

	always_ff @(posedge clk) begin
		result_joint <= s1_joint;
		result_angle <= sat;
	end

endmodule

// File: hdl/ik_pkg.sv
// shared widths, register map and joint-to-axis rule for the IK solver block
// imported by every RTL module and mirrored by the testbench model
package ik_pkg;

	// datapath sizes
	localparam int NUM_JOINT   = 6;
	localparam int ANGLE_W     = 21;
	localparam int TARGET_W    = 27;
	localparam int JOINT_IDX_W = 3;
	localparam int ITER_W      = 4;

	// error is scaled by 1/8 each pass
	localparam int STEP_SHIFT = 3;

	// all joints revolute, read only
	localparam logic [NUM_JOINT-1:0] JOINT_TYPE = '1;

	// sparse word address map
	localparam logic [5:0] ADDR_TYPE  = 6'd0;
	localparam logic [5:0] ADDR_CTRL  = 6'd1;
	localparam logic [5:0] ADDR_TGT_X = 6'd2;
	localparam logic [5:0] ADDR_ITER  = 6'd3;
	localparam logic [5:0] ADDR_TGT_Y = 6'd4;
	localparam logic [5:0] ADDR_TGT_Z = 6'd6;

	// joint i angle lives at base + stride * i
	localparam int ADDR_ANGLE_BASE   = 16;
	localparam int ADDR_ANGLE_STRIDE = 8;

	// joints 0/3 follow x, 1/4 follow y, 2/5 follow z
	function automatic logic [1:0] axis_of(input logic [JOINT_IDX_W-1:0] joint);
		logic [JOINT_IDX_W-1:0] axis;
		axis = joint % 3;
		return axis[1:0];
	endfunction

endpackage
